/* rtl/adapt_fifo_pkg.sv */
/*
 * Adapter FIFO shared definitions
 * Sizes, pointer and count types, stored word and arbiter states
 */

package adapt_fifo_pkg;

  //************************************************************
  // Sizes
  //************************************************************
  localparam int AWIDTH    = 4;             // Address bits
  localparam int DEPTH     = 1 << AWIDTH;   // Words in FIFO
  localparam int DWIDTH    = 16;            // Payload bits
  localparam int NUM_LANES = 2;             // Producer lanes

  // Pointer with wrap bit, binary or Gray
  typedef logic [AWIDTH:0] ptr_t;

  // Word count, wide enough to hold DEPTH
  typedef logic [AWIDTH:0] count_t;

  // Source lane of a word
  typedef enum logic {
    LANE_A = 1'b0,
    LANE_B = 1'b1
  } lane_id_e;

  // Stored word, lane tag on top
  typedef struct packed {
    lane_id_e            lane;     // Producer tag
    logic [DWIDTH-1:0]   payload;  // Data
  } fifo_word_t;

  // Lane arbiter FSM
  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,  // Look for requests
    ARB_WRITE   = 2'd1,  // Wait for room, then write
    ARB_ACK     = 2'd2,  // Ack high until req drops
    ARB_RELEASE = 2'd3   // Ack low, back to idle
  } arb_state_e;

endpackage

/* rtl/adapt_bit_sync.sv */
/*
 * Two-flop synchronizer for a Gray-coded pointer
 */

module adapt_bit_sync
  import adapt_fifo_pkg::*;
(
  input  logic clk,       // Destination clock
  input  logic rst_n,     // Destination reset
  input  ptr_t data_in,   // Gray pointer, source domain
  output ptr_t data_out   // Gray pointer, destination domain
);

  ptr_t meta_q;  // First stage, may settle late

  // One Gray bit moves per step, so either old or new value lands
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      meta_q   <= '0;
      data_out <= '0;
    end
    else
    begin
      meta_q   <= data_in;
      data_out <= meta_q;   // Second stage
    end
  end

endmodule

/* rtl/adapt_fifo_ptr.sv */
/*
 * Adapter FIFO pointer block
 * Binary and Gray pointers per domain, cross-domain sync,
 * word counts and the one-hot write select
 */

module adapt_fifo_ptr
  import adapt_fifo_pkg::*;
(
  input  logic              wr_clk,    // Write clock
  input  logic              wr_rst_n,  // Write reset
  input  logic              rd_clk,    // Read clock
  input  logic              rd_rst_n,  // Read reset
  input  logic              wr_en,     // Write strobe from arbiter
  input  logic              rd_take,   // Pop request from consumer
  output logic [DEPTH-1:0]  wr_sel,    // One-hot write select
  output logic [AWIDTH-1:0] rd_addr,   // Binary read address
  output count_t            wr_count,  // Occupancy seen by writer
  output count_t            rd_count   // Occupancy seen by reader
);

  // Write domain
  ptr_t wr_bin_q;      // Binary write pointer
  ptr_t wr_gray_q;     // Gray write pointer, sent across
  ptr_t wr_bin_nxt;
  ptr_t rd_gray_sync;  // Read pointer in write domain, Gray
  ptr_t rd_bin_sync;   // Same, back to binary

  // Read domain
  ptr_t rd_bin_q;      // Binary read pointer
  ptr_t rd_gray_q;     // Gray read pointer, sent across
  ptr_t rd_bin_nxt;
  ptr_t wr_gray_sync;  // Write pointer in read domain, Gray
  ptr_t wr_bin_sync;   // Same, back to binary
  logic rd_pop;        // Take qualified by non-empty

  // Gray to binary, MSB down
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[AWIDTH] = gray[AWIDTH];
    for (int i = AWIDTH - 1; i >= 0; i--)
    begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // Address to one-hot select
  function automatic logic [DEPTH-1:0] bin_to_onehot(input logic [AWIDTH-1:0] addr);
    logic [DEPTH-1:0] sel;
    sel       = '0;
    sel[addr] = 1'b1;
    return sel;
  endfunction

  //************************************************************
  // Write clock domain
  //************************************************************
  assign wr_bin_nxt = wr_bin_q + ptr_t'(wr_en);   // Writer never writes when full

  always_ff @(posedge wr_clk or negedge wr_rst_n)
  begin
    if (!wr_rst_n)
    begin
      wr_bin_q  <= '0;
      wr_gray_q <= '0;
    end
    else
    begin
      wr_bin_q  <= wr_bin_nxt;
      wr_gray_q <= (wr_bin_nxt >> 1) ^ wr_bin_nxt;  // Registered Gray, glitch free
    end
  end

  assign wr_sel = bin_to_onehot(wr_bin_q[AWIDTH-1:0]);

  // Read pointer into write domain
  adapt_bit_sync i_sync_rd2wr (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .data_in  (rd_gray_q),
    .data_out (rd_gray_sync)
  );

  assign rd_bin_sync = gray_to_bin(rd_gray_sync);
  assign wr_count    = wr_bin_q - rd_bin_sync;   // Stale read ptr, overstates only

  //************************************************************
  // Read clock domain
  //************************************************************
  assign rd_pop     = rd_take && (rd_count != '0);  // Ignore take when empty
  assign rd_bin_nxt = rd_bin_q + ptr_t'(rd_pop);

  always_ff @(posedge rd_clk or negedge rd_rst_n)
  begin
    if (!rd_rst_n)
    begin
      rd_bin_q  <= '0;
      rd_gray_q <= '0;
    end
    else
    begin
      rd_bin_q  <= rd_bin_nxt;
      rd_gray_q <= (rd_bin_nxt >> 1) ^ rd_bin_nxt;
    end
  end

  assign rd_addr = rd_bin_q[AWIDTH-1:0];   // Head entry

  // Write pointer into read domain
  adapt_bit_sync i_sync_wr2rd (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .data_in  (wr_gray_q),
    .data_out (wr_gray_sync)
  );

  assign wr_bin_sync = gray_to_bin(wr_gray_sync);
  assign rd_count    = wr_bin_sync - rd_bin_q;   // Late write ptr, understates only

endmodule

/* rtl/adapt_fifo_mem.sv */
/*
 * Adapter FIFO storage
 * Register array, one-hot write on wr_clk, combinational read
 */

module adapt_fifo_mem
  import adapt_fifo_pkg::*;
(
  input  logic              wr_clk,   // Write clock
  input  logic [DEPTH-1:0]  wr_sel,   // One-hot entry select
  input  logic              wr_en,    // Write strobe
  input  fifo_word_t        wr_word,  // Word to store
  input  logic [AWIDTH-1:0] rd_addr,  // Head address
  output fifo_word_t        rd_word   // Head word
);

  fifo_word_t mem [DEPTH];  // Storage, no reset

  //************************************************************
  // Write port
  //************************************************************
  always_ff @(posedge wr_clk)
  begin
    if (wr_en)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        if (wr_sel[i])
          mem[i] <= wr_word;  // Only the selected entry loads
      end
    end
  end

  // Read mux, unregistered
  assign rd_word = mem[rd_addr];

endmodule

/* rtl/adapt_lane_arb.sv */
/*
 * Round-robin lane arbiter
 * Grants one producer lane, writes its word once the FIFO has room,
 * then finishes the four-phase req/ack handshake
 */

module adapt_lane_arb
  import adapt_fifo_pkg::*;
(
  input  logic                 wr_clk,                 // Write clock
  input  logic                 wr_rst_n,               // Write reset
  input  logic [NUM_LANES-1:0] lane_req,               // Producer requests
  input  fifo_word_t           lane_word [NUM_LANES],  // Producer words
  output logic [NUM_LANES-1:0] lane_ack,               // Handshake acks
  input  count_t               wr_count,               // Writer-side occupancy
  output logic                 wr_en,                  // One strobe per handshake
  output fifo_word_t           wr_word                 // Granted word
);

  arb_state_e state_q;     // FSM state
  lane_id_e   grant_q;     // Lane being served
  lane_id_e   prio_q;      // Lane that wins a tie
  lane_id_e   other_lane;  // Lane without priority
  lane_id_e   pick_lane;   // Winner this cycle
  logic       pick_valid;  // Some lane requests
  logic       room;        // FIFO not full

  //************************************************************
  // Round-robin pick
  //************************************************************
  assign other_lane = (prio_q == LANE_A) ? LANE_B : LANE_A;

  always_comb
  begin
    pick_valid = lane_req[prio_q] || lane_req[other_lane];
    if (lane_req[prio_q])
      pick_lane = prio_q;       // Priority lane first
    else
      pick_lane = other_lane;
  end

  assign room  = (wr_count < count_t'(DEPTH));
  assign wr_en = (state_q == ARB_WRITE) && room;

  //************************************************************
  // Handshake FSM
  //************************************************************
  always_ff @(posedge wr_clk or negedge wr_rst_n)
  begin
    if (!wr_rst_n)
    begin
      state_q <= ARB_IDLE;
      grant_q <= LANE_A;
      prio_q  <= LANE_A;
    end
    else
    begin
      case (state_q)
        ARB_IDLE:
          if (pick_valid)
          begin
            grant_q <= pick_lane;
            prio_q  <= (pick_lane == LANE_A) ? LANE_B : LANE_A;  // Served lane yields
            state_q <= ARB_WRITE;
          end
        ARB_WRITE:
          if (room)
            state_q <= ARB_ACK;   // Write goes out this cycle
        ARB_ACK:
          if (!lane_req[grant_q])
            state_q <= ARB_RELEASE;
        default:
          state_q <= ARB_IDLE;    // ARB_RELEASE, ack already low
      endcase
    end
  end

  // Word capture at grant
  always_ff @(posedge wr_clk)
  begin
    if ((state_q == ARB_IDLE) && pick_valid)
      wr_word <= lane_word[pick_lane];
  end

  // Ack only while in ARB_ACK
  always_comb
  begin
    lane_ack = '0;
    if (state_q == ARB_ACK)
      lane_ack[grant_q] = 1'b1;
  end

endmodule

/* rtl/adapt_fifo_top.sv */
/*
 * Dual-clock adapter FIFO, top level
 * Two req/ack producer lanes in, valid/take read port out
 */

module adapt_fifo_top
  import adapt_fifo_pkg::*;
(
  // Write side
  input  logic                 wr_clk,                 // Write clock
  input  logic                 wr_rst_n,               // Write reset
  input  logic [NUM_LANES-1:0] lane_req,               // Producer requests
  input  fifo_word_t           lane_word [NUM_LANES],  // Producer words
  output logic [NUM_LANES-1:0] lane_ack,               // Handshake acks
  // Read side
  input  logic                 rd_clk,                 // Read clock
  input  logic                 rd_rst_n,               // Read reset
  output logic                 rd_valid,               // Head word present
  output fifo_word_t           rd_word,                // Head word
  input  logic                 rd_take                 // Pop head
);

  logic              wr_en;     // Arbiter write strobe
  fifo_word_t        wr_word;   // Arbiter word to memory
  count_t            wr_count;  // Writer-side occupancy
  count_t            rd_count;  // Reader-side occupancy
  logic [DEPTH-1:0]  wr_sel;    // One-hot write entry
  logic [AWIDTH-1:0] rd_addr;   // Head address

  // Lane arbiter, sole FIFO writer
  adapt_lane_arb i_arb (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .lane_req  (lane_req),
    .lane_word (lane_word),
    .lane_ack  (lane_ack),
    .wr_count  (wr_count),
    .wr_en     (wr_en),
    .wr_word   (wr_word)
  );

  // Pointers and counts, both domains
  adapt_fifo_ptr i_ptr (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr_en    (wr_en),
    .rd_take  (rd_take),
    .wr_sel   (wr_sel),
    .rd_addr  (rd_addr),
    .wr_count (wr_count),
    .rd_count (rd_count)
  );

  // Register-array storage
  adapt_fifo_mem i_mem (
    .wr_clk  (wr_clk),
    .wr_sel  (wr_sel),
    .wr_en   (wr_en),
    .wr_word (wr_word),
    .rd_addr (rd_addr),
    .rd_word (rd_word)
  );

  assign rd_valid = |rd_count;  // Non-empty in read domain

endmodule

/* bench/tb_clkgen.sv */
/*
 * Testbench clock generator
 * Free-running clock plus an active-low reset held for two cycles
 */

module tb_clkgen #(
  parameter int PERIOD = 100   // Clock period in time units
) (
  output logic clk,            // Generated clock
  output logic rst_n           // Reset, low for two cycles
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;           // Release just after the edge
  end

endmodule

/* bench/tb_adapt_fifo.sv */
/*
 * Adapter FIFO testbench
 * Two four-phase lane drivers, a read driver and a mid-cycle compare
 * against a reference payload per lane and index
 */

module tb_adapt_fifo
  import adapt_fifo_pkg::*;
();

  localparam int          DRV_DLY    = 5;              // Drive delay after edge
  localparam int          MAX_CYCLES = 20000;          // 400 words x worst stall, margin
  localparam logic [31:0] SEED       = 32'hebbf_d167;

  logic                 wr_clk;
  logic                 wr_rst_n;
  logic                 rd_clk;
  logic                 rd_rst_n;
  logic                 req_a;        // Lane A request
  logic                 req_b;        // Lane B request
  fifo_word_t           word_a;
  fifo_word_t           word_b;
  logic [NUM_LANES-1:0] lane_req;
  fifo_word_t           lane_word [NUM_LANES];
  logic [NUM_LANES-1:0] lane_ack;
  logic                 rd_valid;
  fifo_word_t           rd_word;
  logic                 rd_take;

  logic [31:0]       rng [3];                // Streams: lane A, lane B, reader
  int                sent_idx [NUM_LANES];   // Words acked per lane
  int                next_idx [NUM_LANES];   // Words popped per lane
  int                ack_count;
  int                pop_count;
  int                pop_errors;             // From compare process
  int                flow_errors;            // From main sequence
  int                cycle_count;
  int                base;
  logic              check_alternation;      // Test 3 only
  logic              alt_armed;
  lane_id_e          prev_lane;
  logic [DWIDTH-1:0] exp_payload;

  assign lane_req     = {req_b, req_a};
  assign lane_word[0] = word_a;
  assign lane_word[1] = word_b;

  tb_clkgen #(.PERIOD(70))  i_wr_clkgen (.clk(wr_clk), .rst_n(wr_rst_n));
  tb_clkgen #(.PERIOD(100)) i_rd_clkgen (.clk(rd_clk), .rst_n(rd_rst_n));

  adapt_fifo_top i_dut (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .lane_req  (lane_req),
    .lane_word (lane_word),
    .lane_ack  (lane_ack),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_valid  (rd_valid),
    .rd_word   (rd_word),
    .rd_take   (rd_take)
  );

  //************************************************************
  // Random source and reference model
  //************************************************************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int rand_below(input int stream, input int limit);
    rng[stream] = xorshift32(rng[stream]);
    return int'(rng[stream] % 32'(limit));
  endfunction

  // Payload from lane tag and sequence index
  function automatic logic [DWIDTH-1:0] expected_payload(input lane_id_e lane, input int idx);
    logic [31:0] mix;
    mix = 32'(idx) ^ 32'h9e37_79b9;
    mix = mix ^ ((lane == LANE_B) ? 32'h6b2f_0000 : 32'h1d47_0000);
    mix = xorshift32(mix);
    return mix[15:0] ^ mix[31:16];
  endfunction

  //************************************************************
  // Drivers
  //************************************************************
  task automatic set_lane(input lane_id_e lane, input logic req, input int idx);
    if (lane == LANE_A)
    begin
      word_a.lane    = LANE_A;
      word_a.payload = expected_payload(LANE_A, idx);
      req_a          = req;
    end
    else
    begin
      word_b.lane    = LANE_B;
      word_b.payload = expected_payload(LANE_B, idx);
      req_b          = req;
    end
  endtask

  // Four phases per word, optional random idle gap first
  task automatic drive_lane(input lane_id_e lane, input int count, input bit gaps);
    int gap;
    for (int n = 0; n < count; n++)
    begin
      if (gaps)
      begin
        gap = rand_below(int'(lane), 8);
        repeat (gap) @(posedge wr_clk);
      end
      @(posedge wr_clk);
      #DRV_DLY;
      set_lane(lane, 1'b1, sent_idx[lane]);      // Phase 1, word stable
      do
      begin
        @(posedge wr_clk);
        #DRV_DLY;
      end while (!lane_ack[lane]);             // Phase 2 from arbiter
      ack_count++;
      set_lane(lane, 1'b0, sent_idx[lane]);      // Phase 3
      do
      begin
        @(posedge wr_clk);
        #DRV_DLY;
      end while (lane_ack[lane]);              // Phase 4
      sent_idx[lane]++;
    end
  endtask

  // Hold take until count more words popped
  task automatic read_words(input int count, input bit random_stall);
    int target;
    target = pop_count + count;
    @(posedge rd_clk);
    #DRV_DLY;
    while (pop_count < target)
    begin
      rd_take = random_stall ? (rand_below(2, 4) != 0) : 1'b1;
      @(posedge rd_clk);
      #DRV_DLY;
    end
    rd_take = 1'b0;
  endtask

  // Take held high for a fixed stretch
  task automatic read_idle(input int cycles);
    @(posedge rd_clk);
    #DRV_DLY;
    rd_take = 1'b1;
    repeat (cycles) @(posedge rd_clk);
    #DRV_DLY;
    rd_take = 1'b0;
  endtask

  task automatic expect_int(input string what, input int got, input int want);
    if (got != want)
    begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
      flow_errors++;
    end
  endtask

  //************************************************************
  // Compare process, mid-cycle, pop lands on next rising edge
  //************************************************************
  always @(negedge rd_clk)
  begin
    if (!check_alternation)
      alt_armed = 1'b0;
    if (rd_rst_n && rd_valid && rd_take)
    begin
      exp_payload = expected_payload(rd_word.lane, next_idx[rd_word.lane]);
      if (rd_word.payload !== exp_payload)
      begin
        $display("Mismatch at %0t: lane %s word %0d payload %h, expected %h", $time,
                 rd_word.lane.name(), next_idx[rd_word.lane], rd_word.payload, exp_payload);
        pop_errors++;
      end
      if (check_alternation && alt_armed && (rd_word.lane == prev_lane))
      begin
        $display("Mismatch at %0t: lane %s popped twice in a row", $time,
                 rd_word.lane.name());
        pop_errors++;
      end
      alt_armed = check_alternation;
      prev_lane = rd_word.lane;
      next_idx[rd_word.lane]++;
      pop_count++;
    end
  end

  // Hang guard
  always @(posedge rd_clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Simulation hung: still running after %0d read clock cycles", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  //************************************************************
  // Main sequence
  //************************************************************
  initial
  begin
    req_a = 1'b0;
    req_b = 1'b0;
    word_a = '0;
    word_b = '0;
    rd_take = 1'b0;
    rng[0] = SEED;
    rng[1] = xorshift32(SEED);
    rng[2] = xorshift32(xorshift32(SEED));
    sent_idx = '{0, 0};
    next_idx = '{0, 0};
    ack_count = 0;
    pop_count = 0;
    pop_errors = 0;
    flow_errors = 0;
    cycle_count = 0;
    check_alternation = 1'b0;
    alt_armed = 1'b0;
    prev_lane = LANE_A;

    wait (rd_rst_n && wr_rst_n);

    // Reset state, quiet until first req
    repeat (8)
    begin
      @(posedge rd_clk);
      #DRV_DLY;
      if ((rd_valid !== 1'b0) || (lane_ack !== '0))
      begin
        $display("Mismatch at %0t: valid %b ack %b after reset", $time, rd_valid, lane_ack);
        flow_errors++;
      end
    end

    // Single word, empty reads pop nothing
    read_idle(4);
    expect_int("pops from empty FIFO", pop_count, 0);
    drive_lane(LANE_A, 1, 1'b0);
    read_words(1, 1'b0);
    if (rd_valid !== 1'b0)
    begin
      $display("Mismatch at %0t: rd_valid still high after last pop", $time);
      flow_errors++;
    end
    read_idle(4);
    expect_int("pops after single word", pop_count, 1);
    expect_int("lane A words popped", next_idx[LANE_A], 1);

    // Both lanes requesting, round robin
    check_alternation = 1'b1;
    fork
      drive_lane(LANE_A, 8, 1'b0);
      drive_lane(LANE_B, 8, 1'b0);
      read_words(16, 1'b0);
    join
    check_alternation = 1'b0;
    expect_int("lane B words popped", next_idx[LANE_B], 8);
    repeat (10) @(posedge wr_clk);      // Read pointer settles on write side

    // Full FIFO, reader stalled
    base = ack_count;
    fork
      drive_lane(LANE_A, DEPTH + 1, 1'b0);
      begin
        while (ack_count < base + DEPTH)
          @(posedge wr_clk);
        repeat (30) @(posedge wr_clk);
        #DRV_DLY;
        expect_int("acks while full", ack_count - base, DEPTH);
        if ((lane_ack[LANE_A] !== 1'b0) || (req_a !== 1'b1))
        begin
          $display("Mismatch at %0t: ack %b req %b while full", $time, lane_ack, req_a);
          flow_errors++;
        end
        read_words(1, 1'b0);            // Frees one slot
      end
    join
    read_words(DEPTH, 1'b0);
    expect_int("lane A words popped", next_idx[LANE_A], 1 + 8 + DEPTH + 1);

    // Random gaps and stalls
    fork
      drive_lane(LANE_A, 200, 1'b1);
      drive_lane(LANE_B, 200, 1'b1);
      read_words(400, 1'b1);
    join
    read_idle(8);                       // Any word left over pops here
    expect_int("total pops against acks", pop_count, ack_count);
    expect_int("lane A order", next_idx[LANE_A], sent_idx[LANE_A]);
    expect_int("lane B order", next_idx[LANE_B], sent_idx[LANE_B]);

    $display("Done: %0d pop errors, %0d flow errors, %0d words popped, %0d acks",
             pop_errors, flow_errors, pop_count, ack_count);
    if ((pop_errors == 0) && (flow_errors == 0))
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

/* adapt_fifo.f */
rtl/adapt_fifo_pkg.sv
rtl/adapt_bit_sync.sv
rtl/adapt_fifo_ptr.sv
rtl/adapt_fifo_mem.sv
rtl/adapt_lane_arb.sv
rtl/adapt_fifo_top.sv
bench/tb_clkgen.sv
bench/tb_adapt_fifo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the adapter FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing \
  -f adapt_fifo.f \
  --top-module tb_adapt_fifo \
  -o tb_adapt_fifo

./obj_dir/tb_adapt_fifo | tee "$LOG"

# Verdict comes from the log
if grep -q "Regression failed" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure, see $LOG"
